//--- src/icache_config.svh
`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// ----------------------------------------------------------------------
// sizes of the instruction cache
// ----------------------------------------------------------------------

// fetch addresses are byte addresses
`define ICACHE_ADR_W 32

// one line holds four 32-bit instruction words
`define ICACHE_LINE_W 128

// L1 is small and sits in distributed RAM
`define L1_LINES 64

// L2 is large and sits in block RAM
`define L2_LINES 2048

// bits below the line address select a byte within the line
`define OFFSET_W 4

`endif

//--- src/icacheLinePkg.sv
`include "icache_config.svh"

// types for what the cache stores and how an address is cut up
package icacheLinePkg;

	// one cache line as it comes from memory
	typedef logic [`ICACHE_LINE_W-1:0] lineT;

	// fault bits that travel with every line
	// busErr is set when the memory access failed
	// execViol is set when the line may not be executed
	typedef struct packed {
		logic busErr;
		logic execViol;
	} faultT;

	// the fetch address without its byte offset
	// this is also what the tag arrays hold
	typedef logic [`ICACHE_ADR_W-`OFFSET_W-1:0] lineAdrT;

	// the low bits of the line address select a line in each level
	typedef logic [$clog2(`L1_LINES)-1:0] l1IndexT;
	typedef logic [$clog2(`L2_LINES)-1:0] l2IndexT;

endpackage

//--- src/icacheCtrlPkg.sv
`include "icache_config.svh"

// types for the register port and the miss handling
package icacheCtrlPkg;

	// register map of the control block
	typedef enum logic [1:0] {
		CTRL    = 2'd0,
		INVLINE = 2'd1,
		INVALL  = 2'd2,
		REFILLS = 2'd3
	} regAdrT;

	// a CTRL write only looks at bit 0
	typedef struct packed {
		logic [30:0] reserved;
		logic        fillEn;
	} ctrlFieldsT;

	// an INVLINE write carries a byte address
	typedef struct packed {
		icacheLinePkg::lineAdrT lineAdr;
		logic [`OFFSET_W-1:0]   offset;
	} byteAdrT;

	// one register write word with two readings
	typedef union packed {
		ctrlFieldsT fields;
		byteAdrT    adr;
	} ctrlWordT;

	// states of the refill sequencer
	typedef enum logic [2:0] {IDLE, L2LOOK, L2CHECK, MEMWAIT, FILL} seqStateT;

endpackage

//--- src/l1LineStore.sv
`timescale 1ns/100ps
`include "icache_config.svh"

// direct mapped L1 with a lookup that answers in the same cycle
module l1LineStore (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [`ICACHE_ADR_W-1:0]  fetchAdr,
	input  logic                      fillWr,
	input  icacheLinePkg::lineT       fillData,
	input  icacheLinePkg::faultT      fillFault,
	input  logic                      invLine,
	input  logic                      invAll,
	input  icacheLinePkg::lineAdrT    invAdr,
	output logic                      hit,
	output icacheLinePkg::lineT       data,
	output icacheLinePkg::faultT      fault
);

	// the tag holds the whole line address so a compare needs no slicing
	icacheLinePkg::lineAdrT tagMem [`L1_LINES];
	icacheLinePkg::lineT    dataMem [`L1_LINES];
	icacheLinePkg::faultT   faultMem [`L1_LINES];
	logic [`L1_LINES-1:0]   valid;

	icacheLinePkg::lineAdrT lineAdr;
	icacheLinePkg::l1IndexT idx;
	icacheLinePkg::l1IndexT invIdx;

	// address bits 9:4 pick the line
	assign lineAdr = fetchAdr[`ICACHE_ADR_W-1:`OFFSET_W];
	assign idx     = icacheLinePkg::l1IndexT'(lineAdr);
	assign invIdx  = icacheLinePkg::l1IndexT'(invAdr);

	// ----------------------------------------------------------------------
	// array writes
	// ----------------------------------------------------------------------

	// the fill always targets the line the fetch unit is waiting on
	always_ff @(posedge clk) begin
		if (fillWr) begin
			tagMem[idx]   <= lineAdr;
			dataMem[idx]  <= fillData;
			faultMem[idx] <= fillFault;
		end
	end

	// an invalidate of one line only drops it if the tag really matches
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (invAll) begin
			valid <= '0;
		end else begin
			if (invLine && tagMem[invIdx] == invAdr)
				valid[invIdx] <= 1'b0;
			if (fillWr)
				valid[idx] <= 1'b1;
		end
	end

	// ----------------------------------------------------------------------
	// lookup
	// ----------------------------------------------------------------------

	assign hit   = valid[idx] && (tagMem[idx] == lineAdr);
	assign data  = dataMem[idx];
	assign fault = faultMem[idx];

	// the sequencer and the register block must not collide on the valid bits
	noFillDuringInvAll: assert property (@(posedge clk) disable iff (rst)
		!(fillWr && invAll));

endmodule

//--- src/l2LineStore.sv
`timescale 1ns/100ps
`include "icache_config.svh"

// direct mapped L2 in block RAM with a registered read address
module l2LineStore (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [`ICACHE_ADR_W-1:0]  lookAdr,
	input  logic                      fillWr,
	input  logic [`ICACHE_ADR_W-1:0]  fillAdr,
	input  icacheLinePkg::lineT       fillData,
	input  icacheLinePkg::faultT      fillFault,
	input  logic                      invLine,
	input  logic                      invAll,
	input  icacheLinePkg::lineAdrT    invAdr,
	output logic                      hit,
	output icacheLinePkg::lineT       data,
	output icacheLinePkg::faultT      fault
);

	icacheLinePkg::lineAdrT tagMem [`L2_LINES];
	icacheLinePkg::lineT    dataMem [`L2_LINES];
	icacheLinePkg::faultT   faultMem [`L2_LINES];

	// valid bits are kept in flops so that invalidate all takes one cycle
	logic [`L2_LINES-1:0]   valid;

	icacheLinePkg::lineAdrT rdLineAdr;
	icacheLinePkg::l2IndexT rdIdx;
	icacheLinePkg::lineAdrT wrLineAdr;
	icacheLinePkg::l2IndexT wrIdx;
	icacheLinePkg::l2IndexT invIdx;

	assign wrLineAdr = fillAdr[`ICACHE_ADR_W-1:`OFFSET_W];
	assign wrIdx     = icacheLinePkg::l2IndexT'(wrLineAdr);
	assign invIdx    = icacheLinePkg::l2IndexT'(invAdr);

	// ----------------------------------------------------------------------
	// read port
	// ----------------------------------------------------------------------

	// the read address is captured every cycle like a block RAM port
	always_ff @(posedge clk) begin
		rdLineAdr <= lookAdr[`ICACHE_ADR_W-1:`OFFSET_W];
	end

	// address bits 14:4 pick the line
	assign rdIdx = icacheLinePkg::l2IndexT'(rdLineAdr);

	assign hit   = valid[rdIdx] && (tagMem[rdIdx] == rdLineAdr);
	assign data  = dataMem[rdIdx];
	assign fault = faultMem[rdIdx];

	// ----------------------------------------------------------------------
	// write port
	// ----------------------------------------------------------------------

	// only lines that came from memory are written here
	always_ff @(posedge clk) begin
		if (fillWr) begin
			tagMem[wrIdx]   <= wrLineAdr;
			dataMem[wrIdx]  <= fillData;
			faultMem[wrIdx] <= fillFault;
		end
	end

	// same rules as L1 so both levels drop a line together
	always_ff @(posedge clk) begin
		if (rst) begin
			valid <= '0;
		end else if (invAll) begin
			valid <= '0;
		end else begin
			if (invLine && tagMem[invIdx] == invAdr)
				valid[invIdx] <= 1'b0;
			if (fillWr)
				valid[wrIdx] <= 1'b1;
		end
	end

endmodule

//--- src/refillSequencer.sv
`timescale 1ns/100ps
`include "icache_config.svh"

// miss handling between L1, L2 and external memory
module refillSequencer (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [`ICACHE_ADR_W-1:0]  fetchAdr,
	input  logic                      l1Miss,
	input  logic                      fillEn,
	output logic                      l2Look,
	input  logic                      l2Hit,
	input  icacheLinePkg::lineT       l2Data,
	input  icacheLinePkg::faultT      l2Fault,
	output logic                      memReq,
	output logic [`ICACHE_ADR_W-1:0]  memAdr,
	input  logic                      memAck,
	input  icacheLinePkg::lineT       memData,
	input  logic                      memBusErr,
	input  logic                      memExecViol,
	output logic                      fillWr,
	output logic                      l2Fill,
	output icacheLinePkg::lineT       fillData,
	output icacheLinePkg::faultT      fillFault,
	output logic                      bypassValid,
	output logic                      refillStart
);

	icacheCtrlPkg::seqStateT state;
	icacheCtrlPkg::seqStateT stateNxt;

	// set when the buffered line came from memory and L2 needs it too
	logic fromMem;

	// ----------------------------------------------------------------------
	// state machine
	// ----------------------------------------------------------------------

	always_comb begin
		stateNxt = state;
		case (state)
			icacheCtrlPkg::IDLE:    if (l1Miss) stateNxt = icacheCtrlPkg::L2LOOK;
			icacheCtrlPkg::L2LOOK:  stateNxt = icacheCtrlPkg::L2CHECK;
			icacheCtrlPkg::L2CHECK: begin
				if (l2Hit)
					stateNxt = icacheCtrlPkg::FILL;
				else
					stateNxt = icacheCtrlPkg::MEMWAIT;
			end
			// memory is the only source of back-pressure
			icacheCtrlPkg::MEMWAIT: if (memAck) stateNxt = icacheCtrlPkg::FILL;
			icacheCtrlPkg::FILL:    stateNxt = icacheCtrlPkg::IDLE;
			default:                stateNxt = icacheCtrlPkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst)
			state <= icacheCtrlPkg::IDLE;
		else
			state <= stateNxt;
	end

	// ----------------------------------------------------------------------
	// line buffer
	// ----------------------------------------------------------------------

	// the miss address is caught once and stays put for the whole refill
	always_ff @(posedge clk) begin
		if (refillStart)
			memAdr <= {fetchAdr[`ICACHE_ADR_W-1:`OFFSET_W], {`OFFSET_W{1'b0}}};
	end

	// the line is taken from L2 on a hit or from memory when it answers
	always_ff @(posedge clk) begin
		if (state == icacheCtrlPkg::L2CHECK && l2Hit) begin
			fillData  <= l2Data;
			fillFault <= l2Fault;
		end else if (state == icacheCtrlPkg::MEMWAIT && memAck) begin
			fillData           <= memData;
			fillFault.busErr   <= memBusErr;
			fillFault.execViol <= memExecViol;
		end
	end

	always_ff @(posedge clk) begin
		if (rst)
			fromMem <= 1'b0;
		else if (state == icacheCtrlPkg::L2CHECK)
			fromMem <= !l2Hit;
	end

	// ----------------------------------------------------------------------
	// outputs
	// ----------------------------------------------------------------------

	assign refillStart = (state == icacheCtrlPkg::IDLE) && l1Miss;
	assign l2Look      = (state == icacheCtrlPkg::L2LOOK);

	// memReq drops in the cycle after memAck because the state has moved on
	assign memReq = (state == icacheCtrlPkg::MEMWAIT);

	// the buffered line is shown to the fetch unit during the fill cycle
	// With fills disabled this is the only cycle in which it is seen
	assign bypassValid = (state == icacheCtrlPkg::FILL);
	assign fillWr      = bypassValid && fillEn;
	assign l2Fill      = fillWr && fromMem;

	// memory may only answer while the request is still open
	memAckInRequest: assert property (@(posedge clk) disable iff (rst)
		memAck |-> memReq);
	// the line asked from memory is still the one the fetch unit holds
	memAdrMatchesFetch: assert property (@(posedge clk) disable iff (rst)
		memReq |-> memAdr[`ICACHE_ADR_W-1:`OFFSET_W] == fetchAdr[`ICACHE_ADR_W-1:`OFFSET_W]);

endmodule

//--- src/cacheControlRegs.sv
`timescale 1ns/100ps

// control registers for fill enable, invalidates and the refill counter
module cacheControlRegs (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    regWr,
	input  icacheCtrlPkg::regAdrT   regAdr,
	input  icacheCtrlPkg::ctrlWordT regWrData,
	output logic [31:0]             regRdData,
	input  logic                    refillStart,
	output logic                    fillEn,
	output logic                    invLine,
	output logic                    invAll,
	output icacheLinePkg::lineAdrT  invAdr
);

	logic [31:0] refills;

	// invalidate strobes are one cycle long and follow the write
	always_ff @(posedge clk) begin
		if (rst) begin
			fillEn  <= 1'b1;
			invLine <= 1'b0;
			invAll  <= 1'b0;
			refills <= '0;
		end else begin
			invLine <= regWr && (regAdr == icacheCtrlPkg::INVLINE);
			invAll  <= regWr && (regAdr == icacheCtrlPkg::INVALL);
			if (regWr && regAdr == icacheCtrlPkg::CTRL)
				fillEn <= regWrData.fields.fillEn;
			if (refillStart)
				refills <= refills + 32'd1;
		end
	end

	// an INVLINE write carries a byte address and only its line part is kept
	always_ff @(posedge clk) begin
		if (regWr && regAdr == icacheCtrlPkg::INVLINE)
			invAdr <= regWrData.adr.lineAdr;
	end

	// reads are combinational and unused bits read as zero
	always_comb begin
		regRdData = '0;
		case (regAdr)
			icacheCtrlPkg::CTRL:    regRdData[0] = fillEn;
			icacheCtrlPkg::REFILLS: regRdData = refills;
			default:                regRdData = '0;
		endcase
	end

endmodule

//--- src/icacheTop.sv
`timescale 1ns/100ps
`include "icache_config.svh"

// two level instruction cache with its control registers
module icacheTop (
	input  logic                      clk,
	input  logic                      rst,
	// fetch side
	input  logic [`ICACHE_ADR_W-1:0]  fetchAdr,
	output logic                      fetchHit,
	output icacheLinePkg::lineT       fetchData,
	output icacheLinePkg::faultT      fetchFault,
	// external memory
	output logic                      memReq,
	output logic [`ICACHE_ADR_W-1:0]  memAdr,
	input  logic                      memAck,
	input  icacheLinePkg::lineT       memData,
	input  logic                      memBusErr,
	input  logic                      memExecViol,
	// register port
	input  logic                      regWr,
	input  icacheCtrlPkg::regAdrT     regAdr,
	input  logic [31:0]               regWrData,
	output logic [31:0]               regRdData
);

	logic                    l1Hit;
	icacheLinePkg::lineT     l1Data;
	icacheLinePkg::faultT    l1Fault;
	logic                    l2Look;
	logic [`ICACHE_ADR_W-1:0] l2LookAdr;
	logic                    l2Hit;
	icacheLinePkg::lineT     l2Data;
	icacheLinePkg::faultT    l2Fault;
	logic                    fillWr;
	logic                    l2Fill;
	icacheLinePkg::lineT     fillData;
	icacheLinePkg::faultT    fillFault;
	logic                    bypassValid;
	logic                    refillStart;
	logic                    fillEn;
	logic                    invLine;
	logic                    invAll;
	icacheLinePkg::lineAdrT  invAdr;

	// the L2 read address only moves for a lookup
	// This keeps the block RAM quiet while L1 is hitting
	assign l2LookAdr = l2Look ? fetchAdr : memAdr;

	l1LineStore i_l1LineStore (
		.clk(clk), .rst(rst), .fetchAdr(fetchAdr),
		.fillWr(fillWr), .fillData(fillData), .fillFault(fillFault),
		.invLine(invLine), .invAll(invAll), .invAdr(invAdr),
		.hit(l1Hit), .data(l1Data), .fault(l1Fault)
	);

	l2LineStore i_l2LineStore (
		.clk(clk), .rst(rst), .lookAdr(l2LookAdr),
		.fillWr(l2Fill), .fillAdr(memAdr), .fillData(fillData), .fillFault(fillFault),
		.invLine(invLine), .invAll(invAll), .invAdr(invAdr),
		.hit(l2Hit), .data(l2Data), .fault(l2Fault)
	);

	refillSequencer i_refillSequencer (
		.clk(clk), .rst(rst), .fetchAdr(fetchAdr), .l1Miss(!l1Hit), .fillEn(fillEn),
		.l2Look(l2Look), .l2Hit(l2Hit), .l2Data(l2Data), .l2Fault(l2Fault),
		.memReq(memReq), .memAdr(memAdr), .memAck(memAck), .memData(memData),
		.memBusErr(memBusErr), .memExecViol(memExecViol),
		.fillWr(fillWr), .l2Fill(l2Fill), .fillData(fillData), .fillFault(fillFault),
		.bypassValid(bypassValid), .refillStart(refillStart)
	);

	cacheControlRegs i_cacheControlRegs (
		.clk(clk), .rst(rst), .regWr(regWr), .regAdr(regAdr),
		.regWrData(regWrData), .regRdData(regRdData), .refillStart(refillStart),
		.fillEn(fillEn), .invLine(invLine), .invAll(invAll), .invAdr(invAdr)
	);

	// during the fill cycle the sequencer's buffer stands in for L1
	assign fetchHit   = l1Hit || bypassValid;
	assign fetchData  = bypassValid ? fillData : l1Data;
	assign fetchFault = bypassValid ? fillFault : l1Fault;

endmodule

//--- testbench/tbIcacheTop.sv
`timescale 1ns/100ps
`include "icache_config.svh"

module tbIcacheTop;

	localparam int clkPeriod = 40;
	localparam int numTests  = 6;

	logic                       clk;
	logic                       rst;
	logic [`ICACHE_ADR_W-1:0]   fetchAdr;
	logic                       fetchHit;
	logic [`ICACHE_LINE_W-1:0]  fetchData;
	icacheLinePkg::faultT       fetchFault;
	logic                       memReq;
	logic [`ICACHE_ADR_W-1:0]   memAdr;
	logic                       memAck;
	logic [`ICACHE_LINE_W-1:0]  memData;
	logic                       memBusErr;
	logic                       memExecViol;
	logic                       regWr;
	icacheCtrlPkg::regAdrT      regAdr;
	logic [31:0]                regWrData;
	logic [31:0]                regRdData;

	// bookkeeping shared by the tests and the memory model
	string       testName;
	logic [31:0] salt;
	int          reqCount;
	int          missCount;

	icacheTop i_icacheTop (
		.clk(clk), .rst(rst), .fetchAdr(fetchAdr), .fetchHit(fetchHit),
		.fetchData(fetchData), .fetchFault(fetchFault),
		.memReq(memReq), .memAdr(memAdr), .memAck(memAck), .memData(memData),
		.memBusErr(memBusErr), .memExecViol(memExecViol),
		.regWr(regWr), .regAdr(regAdr), .regWrData(regWrData), .regRdData(regRdData)
	);

	initial begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// memory model
	// ----------------------------------------------------------------------

	// each 32-bit word of a line is its line address, scrambled by the test's salt
	function automatic logic [`ICACHE_LINE_W-1:0] linePattern(input logic [31:0] adr);
		logic [31:0] word;
		word = {4'h0, adr[31:4]} ^ salt;
		return {word, word, word, word};
	endfunction

	// the upper part of the address space reports a bus error
	function automatic logic busErrFor(input logic [31:0] adr);
		return adr[31:4] >= 28'h0F00000;
	endfunction

	// lines whose address has bit 6 set are marked as not executable
	function automatic logic execViolFor(input logic [31:0] adr);
		return adr[6];
	endfunction

	// memReq is looked at mid cycle, memAck comes 1 to 4 cycles later
	initial begin
		int delay;
		memAck      = 1'b0;
		memData     = '0;
		memBusErr   = 1'b0;
		memExecViol = 1'b0;
		reqCount    = 0;
		forever begin
			@(negedge clk);
			if (memReq) begin
				reqCount = reqCount + 1;
				check("memAdr line aligned", 128'(0), 128'(memAdr[`OFFSET_W-1:0]));
				delay = 1 + ($urandom % 4);
				repeat (delay) @(posedge clk);
				#5;
				memAck      = 1'b1;
				memData     = linePattern(memAdr);
				memBusErr   = busErrFor(memAdr);
				memExecViol = execViolFor(memAdr);
				@(posedge clk);
				#5;
				memAck      = 1'b0;
				memBusErr   = 1'b0;
				memExecViol = 1'b0;
			end
		end
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------

	task automatic check(input string what, input logic [127:0] expected,
			input logic [127:0] actual);
		if (expected !== actual) begin
			$display("[ERROR] %s: %s expected %h actual %h", testName, what, expected, actual);
			$display("TB FAILED");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// counts the cycles from the address to fetchHit, sampled mid cycle
	task automatic waitHit(output int cycles);
		cycles = 0;
		@(negedge clk);
		while (!fetchHit) begin
			cycles = cycles + 1;
			if (cycles > 50) begin
				$display("%s: no fetch hit for address %h after 50 cycles", testName, fetchAdr);
				$display("TB FAILED");
				$fatal(1, "fetch never completed");
			end
			@(negedge clk);
		end
	endtask

	// presents an address, holds it and checks the line that comes back
	task automatic fetch(input logic [31:0] adr, output int latency, output int reqs);
		int reqsBefore;
		@(posedge clk);
		#5;
		fetchAdr   = adr;
		reqsBefore = reqCount;
		waitHit(latency);
		check("fetch data", linePattern(adr), fetchData);
		check("fetch fault", {126'b0, busErrFor(adr), execViolFor(adr)},
			{126'b0, fetchFault});
		reqs = reqCount - reqsBefore;
		// every fetch that did not hit at once started one refill
		if (latency > 0)
			missCount = missCount + 1;
	endtask

	task automatic regWrite(input icacheCtrlPkg::regAdrT adr, input logic [31:0] value);
		@(posedge clk);
		#5;
		regWr     = 1'b1;
		regAdr    = adr;
		regWrData = value;
		@(posedge clk);
		#5;
		regWr     = 1'b0;
	endtask

	task automatic regRead(input icacheCtrlPkg::regAdrT adr, output logic [31:0] value);
		@(posedge clk);
		#5;
		regAdr = adr;
		@(negedge clk);
		value = regRdData;
	endtask

	// ----------------------------------------------------------------------
	// directed tests
	// ----------------------------------------------------------------------

	// the address is already on the bus when reset drops
	task automatic coldMissTest();
		int lat;
		int reqs;
		testName = "cold miss";
		fetch(32'h0000_1230, lat, reqs);
		check("memory requests on first fetch", 128'(1), 128'(reqs));
		fetch(32'h0000_1230, lat, reqs);
		check("latency of second fetch", 128'(0), 128'(lat));
		check("memory requests on second fetch", 128'(0), 128'(reqs));
	endtask

	// same L1 index, L2 indices differ in bit 14
	task automatic conflictRefillTest();
		int lat;
		int reqs;
		testName = "conflict refill";
		salt = 32'h5a5a_0002;
		fetch(32'h0000_2040, lat, reqs);
		check("requests for first line", 128'(1), 128'(reqs));
		fetch(32'h0000_6040, lat, reqs);
		check("requests for second line", 128'(1), 128'(reqs));
		fetch(32'h0000_2040, lat, reqs);
		check("L2 hit latency", 128'(3), 128'(lat));
		check("requests on L2 hit", 128'(0), 128'(reqs));
		fetch(32'h0000_6040, lat, reqs);
		check("L2 hit latency back", 128'(3), 128'(lat));
		check("requests on L2 hit back", 128'(0), 128'(reqs));
	endtask

	task automatic invLineTest();
		int lat;
		int reqs;
		testName = "invalidate line";
		salt = 32'h3c3c_0003;
		fetch(32'h0001_4080, lat, reqs);
		fetch(32'h0001_0080, lat, reqs);
		// park on a line at another index so the invalidate starts no refill
		fetch(32'h0001_0100, lat, reqs);
		regWrite(icacheCtrlPkg::INVLINE, 32'h0001_0080);
		fetch(32'h0001_0080, lat, reqs);
		check("requests after invalidate", 128'(1), 128'(reqs));
		fetch(32'h0001_4080, lat, reqs);
		check("requests for other tag", 128'(0), 128'(reqs));
	endtask

	// the held line is refetched first since it misses right after the clear
	task automatic invAllTest();
		int lat;
		int reqs;
		testName = "invalidate all";
		salt = 32'h0f0f_0004;
		fetch(32'h0002_0200, lat, reqs);
		fetch(32'h0002_0300, lat, reqs);
		fetch(32'h0002_0400, lat, reqs);
		regWrite(icacheCtrlPkg::INVALL, 32'h0);
		fetch(32'h0002_0400, lat, reqs);
		check("requests for held line", 128'(1), 128'(reqs));
		fetch(32'h0002_0200, lat, reqs);
		check("requests for first line", 128'(1), 128'(reqs));
		fetch(32'h0002_0300, lat, reqs);
		check("requests for second line", 128'(1), 128'(reqs));
	endtask

	task automatic faultTest();
		int lat;
		int reqs;
		testName = "fault propagation";
		salt = 32'h9999_0005;
		fetch(32'h0F00_0050, lat, reqs);
		check("requests on faulting miss", 128'(1), 128'(reqs));
		check("busErr on miss", 128'(1), 128'(fetchFault.busErr));
		fetch(32'h0F00_0050, lat, reqs);
		check("latency of faulting hit", 128'(0), 128'(lat));
		check("busErr on hit", 128'(1), 128'(fetchFault.busErr));
	endtask

	// with fills off the held address must move at once to a line that hits
	task automatic fillDisableTest();
		int lat;
		int reqs;
		logic [31:0] value;
		testName = "fill disable";
		salt = 32'h1234_0006;
		fetch(32'h0003_0000, lat, reqs);
		regWrite(icacheCtrlPkg::CTRL, 32'h0);
		repeat (2) begin
			fetch(32'h0003_0560, lat, reqs);
			check("requests with fills off", 128'(1), 128'(reqs));
			fetch(32'h0003_0000, lat, reqs);
			check("parking latency", 128'(0), 128'(lat));
		end
		regRead(icacheCtrlPkg::CTRL, value);
		check("CTRL read with fills off", 128'(0), 128'(value));
		regRead(icacheCtrlPkg::REFILLS, value);
		check("REFILLS count", 128'(missCount), 128'(value));
		regWrite(icacheCtrlPkg::CTRL, 32'h1);
		regRead(icacheCtrlPkg::CTRL, value);
		check("CTRL read with fills on", 128'(1), 128'(value));
	endtask

	// ----------------------------------------------------------------------
	// run control
	// ----------------------------------------------------------------------

	initial begin
		#(numTests * 200 * clkPeriod);
		$display("watchdog expired before the tests finished");
		$display("TB FAILED");
		$fatal(1, "simulation hung");
	end

	initial begin
		void'($urandom(32'h4ded));
		testName  = "reset";
		salt      = 32'ha5a5_0001;
		missCount = 0;
		rst       = 1'b1;
		fetchAdr  = 32'h0000_1230;
		regWr     = 1'b0;
		regAdr    = icacheCtrlPkg::CTRL;
		regWrData = 32'h0;
		repeat (2) @(posedge clk);
		#5;
		rst = 1'b0;
		coldMissTest();
		conflictRefillTest();
		invLineTest();
		invAllTest();
		faultTest();
		fillDisableTest();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- build.f
+incdir+src
src/icacheLinePkg.sv
src/icacheCtrlPkg.sv
src/l1LineStore.sv
src/l2LineStore.sv
src/refillSequencer.sv
src/cacheControlRegs.sv
src/icacheTop.sv
testbench/tbIcacheTop.sv

//--- Makefile
# Verilator flow for the instruction cache testbench

TOP = tbIcacheTop

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^TB PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log
